// File: hw/align_pkg.sv
`default_nettype none

package align_pkg;

  // Buffer geometry, three words are needed to hold a split instruction plus one more
  localparam int BUF_DEPTH       = 3;
  localparam int PTR_W           = 2;
  localparam int CNT_W           = 3;
  localparam int OUT_W           = 2;
  localparam int MAX_OUTSTANDING = 2;

  // Data widths
  localparam int WORD_W = 32;
  localparam int HALF_W = 16;

  // Halfword starts a compressed instruction unless both low bits are set
  function automatic logic is_compressed(input logic [HALF_W-1:0] half);
    return (half[1:0] != 2'b11);
  endfunction

  // Pointer step with wrap at the last buffer word
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

endpackage

`default_nettype wire

// File: hw/align_slot.sv
`timescale 1ns/100ps
`default_nettype none

module align_slot import align_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              wr_en_i,
  input  wire logic              pop_i,
  input  wire logic              kill_i,
  input  wire logic [WORD_W-1:0] wdata_i,
  input  wire logic              werr_i,
  output logic                   valid_o,
  output logic [WORD_W-1:0]      data_o,
  output logic                   err_o,
  output logic                   lo_comp_o,
  output logic                   hi_comp_o
);

  // Valid flag
  // Kill wins, then pop, so a word consumed straight from the bus is not kept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else if (kill_i || pop_i) begin
      valid_o <= 1'b0;
    end else if (wr_en_i) begin
      valid_o <= 1'b1;
    end
  end

  // Payload and halfword predecode, captured with the word
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      data_o    <= wdata_i;
      err_o     <= werr_i;
      lo_comp_o <= is_compressed(wdata_i[HALF_W-1:0]);
      hi_comp_o <= is_compressed(wdata_i[WORD_W-1:HALF_W]);
    end
  end

endmodule

`default_nettype wire

// File: hw/align_intake.sv
`timescale 1ns/100ps
`default_nettype none

module align_intake import align_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              resp_valid_i,
  input  wire logic [WORD_W-1:0] resp_rdata_i,
  input  wire logic              pc_set_i,
  input  wire logic [WORD_W-1:0] branch_addr_i,
  input  wire logic [OUT_W-1:0]  flush_load_i,
  output logic                   resp_live_o,
  output logic [BUF_DEPTH-1:0]   wr_en_o,
  output logic [1:0]             n_incoming_o
);

  logic [OUT_W-1:0] n_flush_q;
  logic [PTR_W-1:0] wptr_q;
  logic             aligned_q, aligned_n;
  logic             complete_q, complete_n;
  logic             lo_comp, hi_comp;

  //////////////////////////////
  // Response gating
  //////////////////////////////

  // Words still owed to fetches from before a branch are dropped here
  assign resp_live_o = resp_valid_i && (n_flush_q == '0);

  // One-hot write strobe for the slot under the write pointer
  always_comb begin
    for (int i = 0; i < BUF_DEPTH; i++) begin
      wr_en_o[i] = resp_live_o && (wptr_q == PTR_W'(i));
    end
  end

  //////////////////////////////
  // Instruction counting
  //////////////////////////////

  assign lo_comp = is_compressed(resp_rdata_i[HALF_W-1:0]);
  assign hi_comp = is_compressed(resp_rdata_i[WORD_W-1:HALF_W]);

  // Complete instructions ending in the arriving word
  always_comb begin
    aligned_n    = aligned_q;
    complete_n   = complete_q;
    n_incoming_o = 2'd0;
    if (pc_set_i) begin
      // Halfword target means the low half of the first word is skipped
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_live_o) begin
      if (aligned_q && !lo_comp) begin
        // Full word instruction, state unchanged
        n_incoming_o = 2'd1;
      end else if (!aligned_q && complete_q) begin
        // First word after a halfword branch, only the upper half counts
        n_incoming_o = hi_comp ? 2'd1 : 2'd0;
        aligned_n    = hi_comp;
        complete_n   = hi_comp;
      end else begin
        // Low half closes an instruction; the upper half may start another
        n_incoming_o = hi_comp ? 2'd2 : 2'd1;
        aligned_n    = hi_comp;
        complete_n   = hi_comp;
      end
    end
  end

  //////////////////////////////
  // State
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      n_flush_q  <= '0;
      wptr_q     <= '0;
      aligned_q  <= 1'b1;
      complete_q <= 1'b0;
    end else begin
      aligned_q  <= aligned_n;
      complete_q <= complete_n;
      if (pc_set_i) begin
        n_flush_q <= flush_load_i;
        wptr_q    <= '0;
      end else begin
        if (resp_valid_i && (n_flush_q != '0)) begin
          n_flush_q <= n_flush_q - 1'b1;
        end
        if (resp_live_o) begin
          wptr_q <= ptr_next(wptr_q);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/align_extract.sv
`timescale 1ns/100ps
`default_nettype none

module align_extract import align_pkg::*; (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             pc_set_i,
  input  wire logic                             kill_if_i,
  input  wire logic [WORD_W-1:0]                branch_addr_i,
  input  wire logic                             resp_live_i,
  input  wire logic [WORD_W-1:0]                resp_rdata_i,
  input  wire logic                             resp_err_i,
  input  wire logic                             instr_ready_i,
  input  wire logic [BUF_DEPTH-1:0]             slot_valid_i,
  input  wire logic [BUF_DEPTH-1:0][WORD_W-1:0] slot_data_i,
  input  wire logic [BUF_DEPTH-1:0]             slot_err_i,
  input  wire logic [BUF_DEPTH-1:0]             slot_lo_comp_i,
  input  wire logic [BUF_DEPTH-1:0]             slot_hi_comp_i,
  output logic                                  instr_valid_o,
  output logic [WORD_W-1:0]                     instr_rdata_o,
  output logic                                  instr_err_o,
  output logic [WORD_W-1:0]                     instr_addr_o,
  output logic [BUF_DEPTH-1:0]                  pop_o,
  output logic                                  instr_taken_o
);

  logic [PTR_W-1:0]  rptr_q, rptr_nxt;
  logic [WORD_W-1:0] addr_n, addr_incr;
  logic              cur_valid, nxt_valid;
  logic [WORD_W-1:0] cur_word;
  logic [HALF_W-1:0] nxt_half;
  logic              cur_err, nxt_err;
  logic              aligned_comp, unaligned_comp;
  logic              any_valid, split_valid;
  logic              pop;

  //////////////////////////////
  // Source selection
  //////////////////////////////

  assign rptr_nxt  = ptr_next(rptr_q);
  assign cur_valid = slot_valid_i[rptr_q];
  assign nxt_valid = slot_valid_i[rptr_nxt];

  // Empty read slot means the live response is bypassed
  assign cur_word = cur_valid ? slot_data_i[rptr_q] : resp_rdata_i;
  assign cur_err  = cur_valid ? slot_err_i[rptr_q]  : resp_err_i;

  // Low half of the following word for split instructions
  assign nxt_half = nxt_valid ? slot_data_i[rptr_nxt][HALF_W-1:0] : resp_rdata_i[HALF_W-1:0];
  assign nxt_err  = nxt_valid ? slot_err_i[rptr_nxt] : resp_err_i;

  // Length bits, predecoded in the slots
  assign aligned_comp   = cur_valid ? slot_lo_comp_i[rptr_q]
                                    : is_compressed(resp_rdata_i[HALF_W-1:0]);
  assign unaligned_comp = cur_valid ? slot_hi_comp_i[rptr_q]
                                    : is_compressed(resp_rdata_i[WORD_W-1:HALF_W]);

  assign any_valid   = cur_valid || resp_live_i;
  // Split word needs both halves present
  assign split_valid = nxt_valid || (cur_valid && resp_live_i);

  //////////////////////////////
  // Decoder output
  //////////////////////////////

  always_comb begin
    instr_rdata_o = cur_word;
    instr_err_o   = cur_err;
    instr_valid_o = any_valid;
    if (instr_addr_o[1]) begin
      instr_rdata_o = {nxt_half, cur_word[WORD_W-1:HALF_W]};
      instr_err_o   = unaligned_comp ? cur_err : (cur_err || nxt_err);
      instr_valid_o = unaligned_comp ? any_valid : split_valid;
    end
    // Kill discards whatever is on the way out
    if (kill_if_i) begin
      instr_valid_o = 1'b0;
    end
  end

  assign instr_taken_o = instr_valid_o && instr_ready_i;

  // Next address and pop of a used-up word
  assign addr_incr = {instr_addr_o[WORD_W-1:2], 2'b00} + WORD_W'(4);

  always_comb begin
    addr_n = instr_addr_o;
    pop    = 1'b0;
    if (instr_taken_o) begin
      if (instr_addr_o[1]) begin
        addr_n = {addr_incr[WORD_W-1:2], unaligned_comp ? 2'b00 : 2'b10};
        pop    = 1'b1;
      end else if (aligned_comp) begin
        addr_n = {instr_addr_o[WORD_W-1:2], 2'b10};
      end else begin
        addr_n = addr_incr;
        pop    = 1'b1;
      end
    end
  end

  always_comb begin
    pop_o = '0;
    if (pop) begin
      pop_o[rptr_q] = 1'b1;
    end
  end

  // Read pointer and address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rptr_q       <= '0;
      instr_addr_o <= '0;
    end else if (pc_set_i) begin
      rptr_q       <= '0;
      instr_addr_o <= branch_addr_i;
    end else begin
      if (pop) begin
        rptr_q <= rptr_nxt;
      end
      instr_addr_o <= addr_n;
    end
  end

endmodule

`default_nettype wire

// File: hw/align_fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module align_fetch_ctrl import align_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              instr_req_i,
  input  wire logic              pc_set_i,
  input  wire logic              kill_if_i,
  input  wire logic [WORD_W-1:0] branch_addr_i,
  input  wire logic              fetch_ready_i,
  input  wire logic              resp_valid_i,
  input  wire logic [1:0]        n_incoming_i,
  input  wire logic              instr_taken_i,
  output logic                   fetch_valid_o,
  output logic                   fetch_branch_o,
  output logic [WORD_W-1:0]      fetch_branch_addr_o,
  output logic                   prefetch_busy_o,
  output logic [OUT_W-1:0]       flush_load_o
);

  logic [CNT_W-1:0] instr_cnt_q;
  logic [OUT_W-1:0] outstanding_q;
  logic             fetch_accept;

  // Keep fetching only while the buffer is nearly drained
  assign fetch_valid_o = instr_req_i &&
                         (outstanding_q < OUT_W'(MAX_OUTSTANDING)) &&
                         ((instr_cnt_q == '0) ||
                          ((instr_cnt_q == CNT_W'(1)) && (outstanding_q == '0)) ||
                          pc_set_i);

  assign prefetch_busy_o = (outstanding_q != '0) || fetch_valid_o;
  assign fetch_accept    = fetch_valid_o && fetch_ready_i;

  // Branch target goes out word aligned
  assign fetch_branch_o      = pc_set_i;
  assign fetch_branch_addr_o = {branch_addr_i[WORD_W-1:2], 2'b00};

  // Responses to drop after a branch; one arriving now is already handled
  assign flush_load_o = resp_valid_i ? outstanding_q - 1'b1 : outstanding_q;

  //////////////////////////////
  // Counters
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_cnt_q   <= '0;
      outstanding_q <= '0;
    end else begin
      // Buffered instructions, emptied on kill
      if (kill_if_i) begin
        instr_cnt_q <= '0;
      end else begin
        instr_cnt_q <= instr_cnt_q + CNT_W'(n_incoming_i) - CNT_W'(instr_taken_i);
      end
      // Outstanding fetches survive a kill, their responses still arrive
      if (fetch_accept && !resp_valid_i) begin
        outstanding_q <= outstanding_q + 1'b1;
      end else if (!fetch_accept && resp_valid_i) begin
        outstanding_q <= outstanding_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/align_buffer_top.sv
`timescale 1ns/100ps
`default_nettype none

module align_buffer_top import align_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              instr_req_i,
  input  wire logic              pc_set_i,
  input  wire logic              kill_if_i,
  input  wire logic [WORD_W-1:0] branch_addr_i,
  input  wire logic              fetch_ready_i,
  input  wire logic              resp_valid_i,
  input  wire logic [WORD_W-1:0] resp_rdata_i,
  input  wire logic              resp_err_i,
  input  wire logic              instr_ready_i,
  output logic                   fetch_valid_o,
  output logic                   fetch_branch_o,
  output logic [WORD_W-1:0]      fetch_branch_addr_o,
  output logic                   prefetch_busy_o,
  output logic                   instr_valid_o,
  output logic [WORD_W-1:0]      instr_rdata_o,
  output logic                   instr_err_o,
  output logic [WORD_W-1:0]      instr_addr_o
);

  logic                             resp_live;
  logic [BUF_DEPTH-1:0]             wr_en, pop;
  logic [BUF_DEPTH-1:0]             slot_valid, slot_err, slot_lo_comp, slot_hi_comp;
  logic [BUF_DEPTH-1:0][WORD_W-1:0] slot_data;
  logic [1:0]                       n_incoming;
  logic                             instr_taken;
  logic [OUT_W-1:0]                 flush_load;

  // Write side
  align_intake u_intake (
    .clk(clk), .rst_n(rst_n),
    .resp_valid_i(resp_valid_i), .resp_rdata_i(resp_rdata_i),
    .pc_set_i(pc_set_i), .branch_addr_i(branch_addr_i), .flush_load_i(flush_load),
    .resp_live_o(resp_live), .wr_en_o(wr_en), .n_incoming_o(n_incoming)
  );

  // Word storage, response word and error broadcast to all slots
  for (genvar i = 0; i < BUF_DEPTH; i++) begin : g_slot
    align_slot u_slot (
      .clk(clk), .rst_n(rst_n),
      .wr_en_i(wr_en[i]), .pop_i(pop[i]), .kill_i(kill_if_i),
      .wdata_i(resp_rdata_i), .werr_i(resp_err_i),
      .valid_o(slot_valid[i]), .data_o(slot_data[i]), .err_o(slot_err[i]),
      .lo_comp_o(slot_lo_comp[i]), .hi_comp_o(slot_hi_comp[i])
    );
  end

  // Read side towards the decoder
  align_extract u_extract (
    .clk(clk), .rst_n(rst_n),
    .pc_set_i(pc_set_i), .kill_if_i(kill_if_i), .branch_addr_i(branch_addr_i),
    .resp_live_i(resp_live), .resp_rdata_i(resp_rdata_i), .resp_err_i(resp_err_i),
    .instr_ready_i(instr_ready_i),
    .slot_valid_i(slot_valid), .slot_data_i(slot_data), .slot_err_i(slot_err),
    .slot_lo_comp_i(slot_lo_comp), .slot_hi_comp_i(slot_hi_comp),
    .instr_valid_o(instr_valid_o), .instr_rdata_o(instr_rdata_o),
    .instr_err_o(instr_err_o), .instr_addr_o(instr_addr_o),
    .pop_o(pop), .instr_taken_o(instr_taken)
  );

  // Fetch throttling and branch handling
  align_fetch_ctrl u_fetch_ctrl (
    .clk(clk), .rst_n(rst_n),
    .instr_req_i(instr_req_i), .pc_set_i(pc_set_i), .kill_if_i(kill_if_i),
    .branch_addr_i(branch_addr_i), .fetch_ready_i(fetch_ready_i),
    .resp_valid_i(resp_valid_i), .n_incoming_i(n_incoming), .instr_taken_i(instr_taken),
    .fetch_valid_o(fetch_valid_o), .fetch_branch_o(fetch_branch_o),
    .fetch_branch_addr_o(fetch_branch_addr_o), .prefetch_busy_o(prefetch_busy_o),
    .flush_load_o(flush_load)
  );

endmodule

`default_nettype wire

// File: test/tb_align_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_align_buffer;

  localparam int CLK_PERIOD = 10;
  localparam int N_INSTR    = 600;
  // Worst case per instruction covers stalls, latency and branch flushes
  localparam int WORST_CYC  = 16;
  localparam int MARGIN_CYC = 200;
  localparam int TIMEOUT_NS = (N_INSTR * WORST_CYC + MARGIN_CYC) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        instr_req_i, pc_set_i, kill_if_i;
  logic [31:0] branch_addr_i;
  logic        fetch_ready_i;
  logic        resp_valid_i;
  logic [31:0] resp_rdata_i;
  logic        resp_err_i;
  logic        instr_ready_i;
  logic        fetch_valid_o, fetch_branch_o;
  logic [31:0] fetch_branch_addr_o;
  logic        prefetch_busy_o;
  logic        instr_valid_o;
  logic [31:0] instr_rdata_o;
  logic        instr_err_o;
  logic [31:0] instr_addr_o;

  // Program image as halfwords with an error flag per word
  logic [15:0] himg [0:511];
  logic        werr [0:255];

  logic [31:0] lcg_state;
  logic        running;
  logic [31:0] fetch_addr, exp_addr, last_target;
  logic        target_check;
  logic [31:0] q_addr [$];
  int          q_due [$];
  int          cyc, last_due, gap, consumed, branches;
  int          n_accepted, n_received;

  align_buffer_top uut (
    .clk(clk), .rst_n(rst_n),
    .instr_req_i(instr_req_i), .pc_set_i(pc_set_i), .kill_if_i(kill_if_i),
    .branch_addr_i(branch_addr_i), .fetch_ready_i(fetch_ready_i),
    .resp_valid_i(resp_valid_i), .resp_rdata_i(resp_rdata_i), .resp_err_i(resp_err_i),
    .instr_ready_i(instr_ready_i),
    .fetch_valid_o(fetch_valid_o), .fetch_branch_o(fetch_branch_o),
    .fetch_branch_addr_o(fetch_branch_addr_o), .prefetch_busy_o(prefetch_busy_o),
    .instr_valid_o(instr_valid_o), .instr_rdata_o(instr_rdata_o),
    .instr_err_o(instr_err_o), .instr_addr_o(instr_addr_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Roughly half the halfwords open a 32-bit instruction
  task automatic fill_image();
    logic [31:0] rnd;
    for (int i = 0; i < 512; i++) begin
      rnd = next_random();
      himg[i] = rnd[31:16];
      if (rnd[15]) begin
        himg[i][1:0] = 2'b11;
      end
    end
    for (int i = 0; i < 256; i++) begin
      werr[i] = (i % 11 == 5);
    end
  endtask

  // Decoder model takes the length from the low bits of the halfword at the address
  task automatic check_instr();
    logic [15:0] h0, h1;
    logic        full, exp_err;
    h0      = himg[exp_addr[9:1]];
    h1      = himg[exp_addr[9:1] + 9'd1];
    full    = (h0[1:0] == 2'b11);
    exp_err = werr[exp_addr[9:2]];
    if (full && exp_addr[1]) begin
      exp_err = werr[exp_addr[9:2]] | werr[exp_addr[9:2] + 8'd1];
    end
    assert (instr_addr_o == exp_addr)
      else report_failure($sformatf("[ERROR] instr_addr_o got %h expected %h",
                                    instr_addr_o, exp_addr));
    if (full) begin
      assert (instr_rdata_o == {h1, h0})
        else report_failure($sformatf("[ERROR] instr_rdata_o got %h expected %h",
                                      instr_rdata_o, {h1, h0}));
    end else begin
      assert (instr_rdata_o[15:0] == h0)
        else report_failure($sformatf("[ERROR] instr_rdata_o[15:0] got %h expected %h",
                                      instr_rdata_o[15:0], h0));
    end
    assert (instr_err_o == exp_err)
      else report_failure($sformatf("[ERROR] instr_err_o got %h expected %h at %h",
                                    instr_err_o, exp_err, exp_addr));
    exp_addr = exp_addr + (full ? 32'd4 : 32'd2);
    consumed = consumed + 1;
  endtask

  //////////////////////////////
  // Concurrent checks
  //////////////////////////////

  // Instruction holds while the decoder stalls
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i) |=>
      ($stable(instr_addr_o) && $stable(instr_err_o) && $stable(instr_rdata_o[15:0]) &&
       ((instr_rdata_o[1:0] != 2'b11) || $stable(instr_rdata_o[31:16]))))
    else report_failure($sformatf(
      "[ERROR] stalled output moved, instr_rdata_o %h instr_addr_o %h",
      instr_rdata_o, instr_addr_o));

  fetch_limit: assert property (@(posedge clk) disable iff (!rst_n)
    (n_accepted - n_received) <= 2)
    else report_failure($sformatf("[ERROR] outstanding fetches %h above 2",
                                  n_accepted - n_received));

  busy_flag: assert property (@(posedge clk) disable iff (!rst_n)
    (n_accepted != n_received) |-> prefetch_busy_o)
    else report_failure($sformatf("[ERROR] prefetch_busy_o is %h with fetches outstanding",
                                  prefetch_busy_o));

  //////////////////////////////
  // Fetch unit and decoder
  //////////////////////////////

  always @(posedge clk) begin : tb_model
    logic [31:0] rnd, tgt, raddr;
    int          lat, due;
    if (running) begin
      cyc = cyc + 1;
      if (target_check) begin
        assert (instr_addr_o == last_target)
          else report_failure($sformatf("[ERROR] instr_addr_o got %h expected %h after branch",
                                        instr_addr_o, last_target));
        target_check = 1'b0;
      end
      if (instr_valid_o && instr_ready_i) begin
        check_instr();
      end
      if (pc_set_i) begin
        assert (fetch_branch_o && (fetch_branch_addr_o == {branch_addr_i[31:2], 2'b00}))
          else report_failure($sformatf("[ERROR] fetch_branch_addr_o got %h expected %h",
                                        fetch_branch_addr_o, {branch_addr_i[31:2], 2'b00}));
        exp_addr     = branch_addr_i;
        last_target  = branch_addr_i;
        target_check = 1'b1;
        branches     = branches + 1;
      end
      // Fetch address restarts at the word holding the target
      if (fetch_branch_o) begin
        fetch_addr = fetch_branch_addr_o;
      end
      rnd = next_random();
      if (fetch_valid_o && fetch_ready_i) begin
        lat = 1 + int'(rnd[31:24]) % 3;
        due = cyc + lat - 1;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        q_addr.push_back(fetch_addr);
        q_due.push_back(due);
        last_due   = due;
        fetch_addr = fetch_addr + 32'd4;
        n_accepted <= n_accepted + 1;
      end
      if (resp_valid_i) begin
        n_received <= n_received + 1;
      end
      // Responses return in order with one word per cycle
      if (q_addr.size() != 0 && q_due[0] <= cyc) begin
        raddr = q_addr.pop_front();
        void'(q_due.pop_front());
        resp_valid_i <= 1'b1;
        resp_rdata_i <= {himg[{raddr[9:2], 1'b1}], himg[{raddr[9:2], 1'b0}]};
        resp_err_i   <= werr[raddr[9:2]];
      end else begin
        resp_valid_i <= 1'b0;
        resp_err_i   <= 1'b0;
      end
      fetch_ready_i <= (rnd[23:22] != 2'b00);
      instr_ready_i <= (rnd[21:19] > 3'd2);
      // One-cycle redirect strobe spaced out by a minimum gap
      if (pc_set_i) begin
        pc_set_i  <= 1'b0;
        kill_if_i <= 1'b0;
        gap       = 0;
      end else begin
        gap = gap + 1;
        if (gap > 6 && rnd[18:15] == 4'd0) begin
          tgt = next_random();
          pc_set_i      <= 1'b1;
          kill_if_i     <= 1'b1;
          branch_addr_i <= {16'h0000, tgt[30:16], 1'b0};
        end
      end
    end
  end

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    instr_req_i = 1'b0;
    pc_set_i = 1'b0;
    kill_if_i = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    resp_valid_i = 1'b0;
    resp_rdata_i = '0;
    resp_err_i = 1'b0;
    instr_ready_i = 1'b0;
    running = 1'b0;
    lcg_state = 32'hff47_7f6a;
    fetch_addr = '0;
    exp_addr = '0;
    last_target = '0;
    target_check = 1'b0;
    cyc = 0;
    last_due = -1;
    gap = 0;
    consumed = 0;
    branches = 0;
    n_accepted = 0;
    n_received = 0;
    fill_image();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Idle with no request
    repeat (2) @(negedge clk);
    assert (!instr_valid_o && !fetch_valid_o && !prefetch_busy_o && !fetch_branch_o)
      else report_failure($sformatf(
        "[ERROR] idle instr_valid_o %h fetch_valid_o %h prefetch_busy_o %h fetch_branch_o %h",
        instr_valid_o, fetch_valid_o, prefetch_busy_o, fetch_branch_o));
    @(posedge clk);
    instr_req_i <= 1'b1;
    running     <= 1'b1;
    while (consumed < N_INSTR) begin
      @(negedge clk);
    end
    $display("%0d instructions checked across %0d branches", consumed, branches);
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    report_failure($sformatf("Timeout with %0d of %0d instructions consumed",
                             consumed, N_INSTR));
  end

endmodule

`default_nettype wire

// File: files.f
hw/align_pkg.sv
hw/align_slot.sv
hw/align_intake.sv
hw/align_extract.sv
hw/align_fetch_ctrl.sv
hw/align_buffer_top.sv
test/tb_align_buffer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the alignment buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_align_buffer -f files.f -o sim_align_buffer > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_align_buffer > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation returned status $sim_status"
  exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
